//--- project.f
+incdir+.
rv32iIsaPkg.sv
rv32iCtrlPkg.sv
idRegfile.sv
idStage.sv
exStage.sv
intCore.sv
intCore_props.sv
tb_intCore.sv

//--- run.sh
#!/usr/bin/env bash
# Build the intCore testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -f project.f --top-module tb_intCore \
    -o tb_intCore > build.log 2>&1 \
    && ./obj_dir/tb_intCore > sim.log 2>&1 \
    || echo "Build or simulation returned an error"

cat build.log sim.log 2>/dev/null
grep -qF -- '*** PASSED ***' sim.log && exit 0 || exit 1

//--- tb_intCore.sv
`default_nettype none

`include "rv32i_params.svh"

module tb_intCore;

    localparam int PERIOD       = 40;
    localparam int RESET_CYCLES = 2;
    localparam int NUM_PRELOAD  = 14;
    localparam int NUM_RANDOM   = 400;
    // Reset reads, preload, random stream and two drain cycles
    localparam int NUM_STEPS    = 2 + NUM_PRELOAD + NUM_RANDOM + 2;

    localparam logic [6:0] OPC_REG = 7'b0110011;
    localparam logic [6:0] OPC_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI = 7'b0110111;

    typedef struct packed {
        logic                   valid;
        logic                   illegal;
        logic [`REG_ADDR_W-1:0] addr;
        logic [`XLEN-1:0]       data;
    } expectT;

    logic                   Clk;
    logic                   rst;
    logic [`XLEN-1:0]       instr;
    logic                   instrValid;
    logic                   wbValid;
    logic [`REG_ADDR_W-1:0] wbAddr;
    logic [`XLEN-1:0]       wbData;
    logic                   illegal;

    // Architectural register state as the ISA defines it
    logic [`XLEN-1:0]       modelRegs [`REG_COUNT];
    expectT                 expQ [$];
    string                  nameQ [$];
    logic [`REG_ADDR_W-1:0] lastRd;
    int                     errorCount;
    int                     checkCount;
    int                     seedDummy;

    intCore UUT (
        .Clk        (Clk),
        .rst        (rst),
        .instr      (instr),
        .instrValid (instrValid),
        .wbValid    (wbValid),
        .wbAddr     (wbAddr),
        .wbData     (wbData),
        .illegal    (illegal)
    );

    always #(PERIOD / 2) Clk = ~Clk;

    //////////////////////////////////////////////////////////////////////
    // Instruction encoding and reference model
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] encodeR(input logic [6:0] f7, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3,
                                            input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_REG};
    endfunction

    function automatic logic [31:0] encodeI(input logic [11:0] imm, input logic [4:0] rs1,
                                            input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, OPC_IMM};
    endfunction

    function automatic logic [31:0] encodeU(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, OPC_LUI};
    endfunction

    function automatic logic [31:0] makeIllegal(input logic [1:0] kind, input logic [4:0] rd,
                                                input logic [4:0] rs1, input logic [4:0] rs2);
        logic [31:0] word;
        case (kind)
            // Load opcode, not supported here
            2'd0:    word = {25'($urandom), 7'b0000011};
            2'd1:    word = encodeR(7'h01, rs2, rs1, 3'b000, rd);
            // XOR has no alternate form
            2'd2:    word = encodeR(7'h20, rs2, rs1, 3'b100, rd);
            default: word = encodeI({7'h20, rs2}, rs1, 3'b001, rd);
        endcase
        return word;
    endfunction

    task automatic referenceResult(input logic [31:0] word, output logic legal,
                                   output logic [31:0] result);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic        alt;
        logic [31:0] a;
        logic [31:0] b;
        opc    = word[6:0];
        f3     = word[14:12];
        alt    = (word[31:25] == 7'h20);
        a      = modelRegs[word[19:15]];
        b      = (opc == OPC_REG) ? modelRegs[word[24:20]] : {{20{word[31]}}, word[31:20]};
        result = '0;
        if (opc == OPC_LUI) begin
            legal  = 1'b1;
            result = {word[31:12], 12'h000};
        end else if (opc == OPC_REG || opc == OPC_IMM) begin
            if (opc == OPC_REG) begin
                legal = (word[31:25] == 7'h00) || (alt && (f3 == 3'b000 || f3 == 3'b101));
            end else if (f3 == 3'b001) begin
                legal = (word[31:25] == 7'h00);
            end else if (f3 == 3'b101) begin
                legal = (word[31:25] == 7'h00) || alt;
            end else begin
                legal = 1'b1;
            end
            case (f3)
                3'b000:  result = (opc == OPC_REG && alt) ? a - b : a + b;
                3'b001:  result = a << b[4:0];
                3'b010:  result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                3'b011:  result = (a < b) ? 32'd1 : 32'd0;
                3'b100:  result = a ^ b;
                3'b101:  result = alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
                3'b110:  result = a | b;
                default: result = a & b;
            endcase
        end else begin
            legal = 1'b0;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus and checking
    //////////////////////////////////////////////////////////////////////

    task automatic reportMismatch(input string name, input string field,
                                  input logic [31:0] expVal, input logic [31:0] actVal);
        errorCount++;
        $display("ERROR %s %s: expected %h, actual %h", name, field, expVal, actVal);
    endtask

    // Outputs here belong to the instruction captured at the last edge
    task automatic checkOutputs();
        expectT e;
        string  name;
        if (expQ.size() > 0) begin
            e    = expQ.pop_front();
            name = nameQ.pop_front();
            checkCount++;
            if (wbValid !== e.valid)
                reportMismatch(name, "wbValid", 32'(e.valid), 32'(wbValid));
            if (illegal !== e.illegal)
                reportMismatch(name, "illegal", 32'(e.illegal), 32'(illegal));
            if (e.valid && wbAddr !== e.addr)
                reportMismatch(name, "wbAddr", 32'(e.addr), 32'(wbAddr));
            if (e.valid && !e.illegal && wbData !== e.data)
                reportMismatch(name, "wbData", e.data, wbData);
        end
    endtask

    task automatic issueStep(input logic valid, input logic [31:0] word, input string name);
        expectT      e;
        logic        legal;
        logic [31:0] result;
        @(posedge Clk);
        #2;
        checkOutputs();
        instrValid = valid;
        instr      = word;
        e          = '0;
        if (valid) begin
            referenceResult(word, legal, result);
            e.valid   = 1'b1;
            e.illegal = !legal;
            e.addr    = word[11:7];
            e.data    = result;
            if (legal && word[11:7] != 5'd0)
                modelRegs[word[11:7]] = result;
            lastRd = word[11:7];
        end
        expQ.push_back(e);
        nameQ.push_back(name);
    endtask

    initial begin
        int         pick;
        int         dep;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [2:0] f3;
        logic [6:0] f7;
        logic [11:0] imm;
        seedDummy  = $urandom(32'h444c);
        Clk        = 1'b0;
        rst        = 1'b1;
        instr      = '0;
        instrValid = 1'b0;
        lastRd     = '0;
        errorCount = 0;
        checkCount = 0;
        for (int i = 0; i < `REG_COUNT; i++)
            modelRegs[i] = '0;

        repeat (RESET_CYCLES) @(posedge Clk);
        #2;
        rst = 1'b0;
        if (wbValid !== 1'b0)
            reportMismatch("reset", "wbValid", 32'd0, 32'(wbValid));
        if (illegal !== 1'b0)
            reportMismatch("reset", "illegal", 32'd0, 32'(illegal));

        // Fresh registers read as zero
        issueStep(1'b1, encodeR(7'h00, 5'd2, 5'd1, 3'b000, 5'd5), "reset_add");
        issueStep(1'b1, encodeR(7'h00, 5'd4, 5'd3, 3'b000, 5'd6), "reset_add");

        // Random operands, ADDI depends on the LUI just before it
        for (int r = 1; r < 8; r++) begin
            issueStep(1'b1, encodeU(20'($urandom), 5'(r)), "preload_lui");
            issueStep(1'b1, encodeI(12'($urandom), 5'(r), 3'b000, 5'(r)), "preload_addi");
        end

        for (int n = 0; n < NUM_RANDOM; n++) begin
            pick = $urandom_range(0, 15);
            rd   = 5'($urandom_range(0, 7));
            rs1  = 5'($urandom_range(0, 7));
            rs2  = 5'($urandom_range(0, 7));
            f3   = 3'($urandom);
            // Lean on the previous rd to hit the bypass
            dep  = $urandom_range(0, 2);
            if (dep == 1)
                rs1 = lastRd;
            else if (dep == 2)
                rs2 = lastRd;
            if (pick <= 5) begin
                f7 = ((f3 == 3'b000 || f3 == 3'b101) && $urandom_range(0, 1) == 1) ? 7'h20
                                                                                    : 7'h00;
                issueStep(1'b1, encodeR(f7, rs2, rs1, f3, rd), "rtype");
            end else if (pick <= 10) begin
                imm = 12'($urandom);
                if (f3 == 3'b001)
                    imm[11:5] = 7'h00;
                else if (f3 == 3'b101)
                    imm[11:5] = ($urandom_range(0, 1) == 1) ? 7'h20 : 7'h00;
                issueStep(1'b1, encodeI(imm, rs1, f3, rd), "itype");
            end else if (pick <= 12) begin
                issueStep(1'b1, encodeU(20'($urandom), rd), "lui");
            end else if (pick == 13) begin
                issueStep(1'b1, makeIllegal(2'($urandom), rd, rs1, rs2), "illegal");
            end else begin
                issueStep(1'b0, $urandom, "gap");
            end
        end

        issueStep(1'b0, 32'h0, "drain");
        issueStep(1'b0, 32'h0, "drain");

        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Watchdog sized from the reset and instruction count
    initial begin
        #((RESET_CYCLES + NUM_STEPS + 20) * PERIOD);
        $display("Watchdog expired before the instruction stream finished");
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- intCore_props.sv
`default_nettype none

`include "rv32i_params.svh"

module intCoreProps (
    input logic                   Clk,
    input logic                   rst,
    input logic                   instrValid,
    input logic                   wbValid,
    input logic [`REG_ADDR_W-1:0] wbAddr,
    input logic                   illegal,
    input logic                   regWrEn
);

    // Reset clears the ID/EX register
    resetClearsWb: assert property (@(posedge Clk) rst |=> !wbValid)
        else $error("wbValid high in the cycle after reset");

    // One cycle from instrValid to wbValid
    validFollowsInstr: assert property (@(posedge Clk) !rst |=> (wbValid == $past(instrValid)))
        else $error("wbValid does not follow instrValid of the previous cycle");

    // Illegal result is reported with wbValid and never written back
    illegalNeedsValid: assert property (@(posedge Clk) disable iff (rst)
        illegal |-> (wbValid && !regWrEn))
        else $error("illegal high without wbValid or with a register write");

    // x0 target must never reach the register file write port
    noX0Write: assert property (@(posedge Clk) disable iff (rst)
        (wbValid && wbAddr == '0) |-> !regWrEn)
        else $error("register file write enabled for x0");

endmodule

bind intCore intCoreProps props (
    .Clk        (Clk),
    .rst        (rst),
    .instrValid (instrValid),
    .wbValid    (wbValid),
    .wbAddr     (wbAddr),
    .illegal    (illegal),
    .regWrEn    (regWrEn)
);

`default_nettype wire

//--- intCore.sv
`default_nettype none

`include "rv32i_params.svh"

module intCore (
    input  logic                   Clk,
    input  logic                   rst,

    input  logic [`XLEN-1:0]       instr,
    input  logic                   instrValid,

    output logic                   wbValid,
    output logic [`REG_ADDR_W-1:0] wbAddr,
    output logic [`XLEN-1:0]       wbData,
    output logic                   illegal
);

    import rv32iCtrlPkg::*;

    // Register file read ports
    logic [`REG_ADDR_W-1:0] rs1Addr;
    logic [`REG_ADDR_W-1:0] rs2Addr;
    logic [`XLEN-1:0]       rs1Data;
    logic [`XLEN-1:0]       rs2Data;

    // ID/EX register
    logic                   exValid;
    aluOpT                  exAluOp;
    logic [`XLEN-1:0]       exOpA;
    logic [`XLEN-1:0]       exOpB;
    logic [`REG_ADDR_W-1:0] exRdAddr;
    logic                   exRegWrEn;
    logic                   exIllegal;

    // EX result, written back and bypassed
    logic                   regWrEn;
    logic [`REG_ADDR_W-1:0] regWrAddr;
    logic [`XLEN-1:0]       regWrData;

    idStage u_idStage (
        .Clk        (Clk),
        .rst        (rst),
        .instr      (instr),
        .instrValid (instrValid),
        .rs1Addr    (rs1Addr),
        .rs2Addr    (rs2Addr),
        .rs1Data    (rs1Data),
        .rs2Data    (rs2Data),
        .bypassEn   (regWrEn),
        .bypassAddr (regWrAddr),
        .bypassData (regWrData),
        .exValid    (exValid),
        .exAluOp    (exAluOp),
        .exOpA      (exOpA),
        .exOpB      (exOpB),
        .exRdAddr   (exRdAddr),
        .exRegWrEn  (exRegWrEn),
        .exIllegal  (exIllegal)
    );

    idRegfile u_idRegfile (
        .Clk     (Clk),
        .rst     (rst),
        .rs1Addr (rs1Addr),
        .rs2Addr (rs2Addr),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data),
        .wrEn    (regWrEn),
        .wrAddr  (regWrAddr),
        .wrData  (regWrData)
    );

    exStage u_exStage (
        .exValid   (exValid),
        .exAluOp   (exAluOp),
        .exOpA     (exOpA),
        .exOpB     (exOpB),
        .exRdAddr  (exRdAddr),
        .exRegWrEn (exRegWrEn),
        .exIllegal (exIllegal),
        .regWrEn   (regWrEn),
        .regWrAddr (regWrAddr),
        .regWrData (regWrData),
        .wbValid   (wbValid),
        .wbAddr    (wbAddr),
        .wbData    (wbData),
        .illegal   (illegal)
    );

endmodule

`default_nettype wire

//--- exStage.sv
`default_nettype none

`include "rv32i_params.svh"

module exStage (
    input  logic                   exValid,
    input  rv32iCtrlPkg::aluOpT    exAluOp,
    input  logic [`XLEN-1:0]       exOpA,
    input  logic [`XLEN-1:0]       exOpB,
    input  logic [`REG_ADDR_W-1:0] exRdAddr,
    input  logic                   exRegWrEn,
    input  logic                   exIllegal,

    // Register file write, also the bypass source
    output logic                   regWrEn,
    output logic [`REG_ADDR_W-1:0] regWrAddr,
    output logic [`XLEN-1:0]       regWrData,

    output logic                   wbValid,
    output logic [`REG_ADDR_W-1:0] wbAddr,
    output logic [`XLEN-1:0]       wbData,
    output logic                   illegal
);

    import rv32iCtrlPkg::*;

    logic [4:0]       shamt;
    logic [`XLEN-1:0] aluResult;

    assign shamt = exOpB[4:0];

    //////////////////////////////////////////////////////////////////////
    // ALU
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (exAluOp)
            ALU_ADD:   aluResult = exOpA + exOpB;
            ALU_SUB:   aluResult = exOpA - exOpB;
            ALU_SLL:   aluResult = exOpA << shamt;
            ALU_SLT:   aluResult = {{(`XLEN-1){1'b0}}, $signed(exOpA) < $signed(exOpB)};
            ALU_SLTU:  aluResult = {{(`XLEN-1){1'b0}}, exOpA < exOpB};
            ALU_XOR:   aluResult = exOpA ^ exOpB;
            ALU_SRL:   aluResult = exOpA >> shamt;
            ALU_SRA:   aluResult = $unsigned($signed(exOpA) >>> shamt);
            ALU_OR:    aluResult = exOpA | exOpB;
            ALU_AND:   aluResult = exOpA & exOpB;
            ALU_PASSB: aluResult = exOpB;
            default:   aluResult = '0;
        endcase
    end

    // Write only for a valid, legal, non-x0 instruction
    assign regWrEn   = exValid && exRegWrEn;
    assign regWrAddr = exRdAddr;
    assign regWrData = aluResult;

    assign wbValid = exValid;
    assign wbAddr  = exRdAddr;
    assign wbData  = aluResult;
    assign illegal = exValid && exIllegal;

endmodule

`default_nettype wire

//--- idStage.sv
`default_nettype none

`include "rv32i_params.svh"

module idStage (
    input  logic                     Clk,
    input  logic                     rst,

    input  logic [`XLEN-1:0]         instr,
    input  logic                     instrValid,

    // Register file read side
    output logic [`REG_ADDR_W-1:0]   rs1Addr,
    output logic [`REG_ADDR_W-1:0]   rs2Addr,
    input  logic [`XLEN-1:0]         rs1Data,
    input  logic [`XLEN-1:0]         rs2Data,

    // Result of the instruction now in EX
    input  logic                     bypassEn,
    input  logic [`REG_ADDR_W-1:0]   bypassAddr,
    input  logic [`XLEN-1:0]         bypassData,

    // ID/EX register
    output logic                     exValid,
    output rv32iCtrlPkg::aluOpT      exAluOp,
    output logic [`XLEN-1:0]         exOpA,
    output logic [`XLEN-1:0]         exOpB,
    output logic [`REG_ADDR_W-1:0]   exRdAddr,
    output logic                     exRegWrEn,
    output logic                     exIllegal
);

    import rv32iIsaPkg::*;
    import rv32iCtrlPkg::*;

    opcodeT                 opcode;
    logic [2:0]             funct3;
    logic [6:0]             funct7;
    logic [`REG_ADDR_W-1:0] rdAddr;
    logic                   baseForm;
    logic                   altForm;
    aluOpT                  groupOp;
    aluOpT                  aluOp;
    srcBT                   srcB;
    logic                   legal;
    logic [`XLEN-1:0]       imm;
    logic [`XLEN-1:0]       opA;
    logic [`XLEN-1:0]       opBReg;
    logic [`XLEN-1:0]       opB;

    //////////////////////////////////////////////////////////////////////
    // Field split
    //////////////////////////////////////////////////////////////////////

    assign opcode   = opcodeT'(instr[6:0]);
    assign rdAddr   = instr[11:7];
    assign funct3   = instr[14:12];
    assign rs1Addr  = instr[19:15];
    assign rs2Addr  = instr[24:20];
    assign funct7   = instr[31:25];
    assign baseForm = (funct7 == F7_BASE);
    assign altForm  = (funct7 == F7_ALT);

    // I-type sign extended, U-type in the upper 20 bits
    assign imm = (opcode == OP_LUI) ? {instr[31:12], 12'b0}
                                    : {{(`XLEN-12){instr[31]}}, instr[31:20]};

    //////////////////////////////////////////////////////////////////////
    // Decode
    //////////////////////////////////////////////////////////////////////

    // Common funct3 mapping for both ALU groups
    always_comb begin
        case (funct3)
            F3_ADD:  groupOp = ALU_ADD;
            F3_SLL:  groupOp = ALU_SLL;
            F3_SLT:  groupOp = ALU_SLT;
            F3_SLTU: groupOp = ALU_SLTU;
            F3_XOR:  groupOp = ALU_XOR;
            F3_SR:   groupOp = altForm ? ALU_SRA : ALU_SRL;
            F3_OR:   groupOp = ALU_OR;
            F3_AND:  groupOp = ALU_AND;
            default: groupOp = ALU_ADD;
        endcase
    end

    always_comb begin
        aluOp = groupOp;
        srcB  = SRCB_REG;
        legal = 1'b0;
        case (opcode)
            OP_REG: begin
                // funct7 0x20 only for SUB and SRA
                aluOp = (funct3 == F3_ADD && altForm) ? ALU_SUB : groupOp;
                legal = baseForm || (altForm && (funct3 == F3_ADD || funct3 == F3_SR));
            end
            OP_IMM: begin
                srcB = SRCB_IMM;
                if (funct3 == F3_SLL) begin
                    legal = baseForm;
                end else if (funct3 == F3_SR) begin
                    legal = baseForm || altForm;
                end else begin
                    legal = 1'b1;
                end
            end
            OP_LUI: begin
                aluOp = ALU_PASSB;
                srcB  = SRCB_IMM;
                legal = 1'b1;
            end
            default: begin
                legal = 1'b0;
            end
        endcase
    end

    // Operand select, EX result wins over the register file
    assign opA    = (bypassEn && bypassAddr == rs1Addr) ? bypassData : rs1Data;
    assign opBReg = (bypassEn && bypassAddr == rs2Addr) ? bypassData : rs2Data;
    assign opB    = (srcB == SRCB_IMM) ? imm : opBReg;

    //////////////////////////////////////////////////////////////////////
    // ID/EX register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge Clk) begin
        if (rst) begin
            exValid   <= 1'b0;
            exAluOp   <= ALU_ADD;
            exOpA     <= '0;
            exOpB     <= '0;
            exRdAddr  <= '0;
            exRegWrEn <= 1'b0;
            exIllegal <= 1'b0;
        end else begin
            exValid   <= instrValid;
            exAluOp   <= aluOp;
            exOpA     <= opA;
            exOpB     <= opB;
            exRdAddr  <= rdAddr;
            // Qualified by exValid in EX
            exRegWrEn <= legal && (rdAddr != '0);
            exIllegal <= !legal;
        end
    end

endmodule

`default_nettype wire

//--- idRegfile.sv
`default_nettype none

`include "rv32i_params.svh"

module idRegfile (
    input  logic                   Clk,
    input  logic                   rst,

    input  logic [`REG_ADDR_W-1:0] rs1Addr,
    input  logic [`REG_ADDR_W-1:0] rs2Addr,
    output logic [`XLEN-1:0]       rs1Data,
    output logic [`XLEN-1:0]       rs2Data,

    input  logic                   wrEn,
    input  logic [`REG_ADDR_W-1:0] wrAddr,
    input  logic [`XLEN-1:0]       wrData
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    // Asynchronous read ports
    assign rs1Data = regs[rs1Addr];
    assign rs2Data = regs[rs2Addr];

    // x0 stays zero since the decoder never enables a write to it
    always_ff @(posedge Clk) begin
        if (rst) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wrAddr] <= wrData;
        end
    end

endmodule

`default_nettype wire

//--- rv32iCtrlPkg.sv
`default_nettype none

package rv32iCtrlPkg;

    // ALU operation carried through ID/EX
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        // Operand B straight through, used by LUI
        ALU_PASSB
    } aluOpT;

    // Second operand source
    typedef enum logic {
        SRCB_REG,
        SRCB_IMM
    } srcBT;

endpackage

`default_nettype wire

//--- rv32iIsaPkg.sv
`default_nettype none

package rv32iIsaPkg;

    //////////////////////////////////////////////////////////////////////
    // Major opcodes, instr[6:0]
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [6:0] {
        OP_REG = 7'b0110011,
        OP_IMM = 7'b0010011,
        OP_LUI = 7'b0110111
    } opcodeT;

    //////////////////////////////////////////////////////////////////////
    // funct3, shared by the register and immediate ALU groups
    //////////////////////////////////////////////////////////////////////

    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    // SRL and SRA, split by funct7
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // funct7 forms
    localparam logic [6:0] F7_BASE = 7'b0000000;
    // Selects SUB and SRA
    localparam logic [6:0] F7_ALT  = 7'b0100000;

endpackage

`default_nettype wire

//--- rv32i_params.svh
`ifndef RV32I_PARAMS_SVH
`define RV32I_PARAMS_SVH

//////////////////////////////////////////////////////////////////////
// Datapath sizes
//////////////////////////////////////////////////////////////////////

// Integer register and ALU width
`define XLEN 32

// Register file geometry, fixed RV32I size
`define REG_ADDR_W 5
`define REG_COUNT  32

`endif
